// ==== verilog/uart_params.svh ====
//////////////////////////////////////////////////
// uart transmit subsystem parameters
// frame format, command FIFO sizing, baud divisor
//////////////////////////////////////////////////

`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

// serial frame
`define dataBits        8   // data bits per frame
`define sbTick          16  // ticks per bit, stop bit too

// command FIFO
`define fifoDepth       16  // entries, also host credits after reset
`define fifoAddrLen     4   // pointer width

// baud generator
`define baudDivLen      8   // divisor width
`define defaultBaudDiv  3   // 4 clocks per tick after reset

// with divisor N a tick comes every N+1 clocks
// so one bit is `sbTick*(N+1) clocks

`endif

// ==== verilog/uartFramePkg.sv ====
//////////////////////////////////////////////////
// types for the serial frame side
// transmitter FSM states and the frame byte
//////////////////////////////////////////////////

`include "uart_params.svh"

package uartFramePkg;

	// serializer FSM, one state per frame section
	typedef enum logic [1:0]
	{
		stIdle  = 2'b00,  // line held at 1
		stStart = 2'b01,  // start bit, line 0
		stData  = 2'b10,  // data bits, lsb first
		stStop  = 2'b11   // stop bit, line 1
	} txStateT;

	// one byte as it goes out on the line
	typedef logic [`dataBits-1:0] txByteT;

	// 8N1 only, no parity field
	// stop bit length is `sbTick ticks

endpackage

// ==== verilog/uartHostPkg.sv ====
//////////////////////////////////////////////////
// types for the host command word
// command kind, payload union, FIFO entry
//////////////////////////////////////////////////

`include "uart_params.svh"

package uartHostPkg;

	// what the payload means
	typedef enum logic
	{
		kindData   = 1'b0,  // byte to send
		kindConfig = 1'b1   // new baud divisor
	} hostKindT;

	// same 8 bits, read two ways depending on kind
	typedef union packed
	{
		logic [`dataBits-1:0]   asData;    // frame byte
		logic [`baudDivLen-1:0] asConfig;  // divisor, N+1 clocks per tick
	} hostPayloadU;

	// host input word and FIFO entry, 9 bits
	typedef struct packed
	{
		hostKindT    kind;     // msb selects the view
		hostPayloadU payload;
	} hostCmdT;

	// one credit per accepted word

endpackage

// ==== verilog/baudTickGen.sv ====
//////////////////////////////////////////////////
// baud tick generator
// programmable down-counter, one tick per N+1 clocks
//////////////////////////////////////////////////

`include "uart_params.svh"

module baudTickGen
(
	input  logic                   clk,
	input  logic                   reset,
	input  logic [`baudDivLen-1:0] baudDiv,  // N
	output logic                   sTick     // 16x bit rate
);

	logic [`baudDivLen-1:0] countReg;  // clocks left until tick
	logic [`baudDivLen-1:0] lastDiv;   // divisor seen last cycle
	logic                   divChange;

	assign divChange = (baudDiv != lastDiv);

	// no tick in the cycle the rate switches
	assign sTick = (countReg == '0) && !divChange;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			countReg <= `baudDivLen'(`defaultBaudDiv);
			lastDiv  <= `baudDivLen'(`defaultBaudDiv);
		end
		else
		begin
			lastDiv <= baudDiv;
			if (divChange || countReg == '0)
				countReg <= baudDiv;  // restart, first tick N+1 clocks on
			else
				countReg <= countReg - 1'b1;
		end
	end

endmodule

// ==== verilog/txIntake.sv ====
//////////////////////////////////////////////////
// command intake
// circular command FIFO with fill count
// credit return on every pop
// head dispatch, byte hand-off or divisor update
//////////////////////////////////////////////////

`include "uart_params.svh"

module txIntake import uartHostPkg::*, uartFramePkg::*;
(
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   cmdValid,      // host write strobe
	input  hostCmdT                cmd,
	output logic                   creditReturn,  // one pulse per pop
	output logic                   txValid,       // head is a byte
	output txByteT                 txByte,
	input  logic                   txAccept,      // serializer took the byte
	input  logic                   busy,          // frame still on the line
	output logic [`baudDivLen-1:0] baudDiv
);

	//////////////////////////////////////////////////
	// storage

	hostCmdT                fifoMem [`fifoDepth];  // payload only, no reset
	logic [`fifoAddrLen-1:0] rdPtr;
	logic [`fifoAddrLen-1:0] wrPtr;
	logic [`fifoAddrLen:0]   fillCnt;               // one bit wider than ptrs

	hostCmdT headCmd;
	logic    isEmpty;
	logic    isFull;
	logic    push;
	logic    pop;
	logic    popData;
	logic    popConfig;

	assign isEmpty = (fillCnt == '0);
	assign isFull  = (fillCnt == (`fifoAddrLen+1)'(`fifoDepth));

	// a write without a credit finds the FIFO full and is dropped
	assign push = cmdValid && !isFull;

	always_ff @(posedge clk)
	begin
		if (push)
			fifoMem[wrPtr] <= cmd;  // stored on the edge with cmdValid
	end

	assign headCmd = fifoMem[rdPtr];  // combinational head read

	//////////////////////////////////////////////////
	// head decode

	// data view goes to the serializer
	assign txValid = !isEmpty && (headCmd.kind == kindData);
	assign txByte  = headCmd.payload.asData;

	assign popData = txValid && txAccept;  // pop in the accept cycle

	// config waits until every earlier frame has left the line
	assign popConfig = !isEmpty && (headCmd.kind == kindConfig) && !busy;

	assign pop          = popData || popConfig;
	assign creditReturn = pop;  // same cycle as the pop

	//////////////////////////////////////////////////
	// pointers, count and divisor

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			rdPtr   <= '0;
			wrPtr   <= '0;
			fillCnt <= '0;
			baudDiv <= `baudDivLen'(`defaultBaudDiv);
		end
		else
		begin
			if (push)
				wrPtr <= wrPtr + 1'b1;  // wraps at depth
			if (pop)
				rdPtr <= rdPtr + 1'b1;

			// push and pop together leave the count alone
			if (push && !pop)
				fillCnt <= fillCnt + 1'b1;
			else if (pop && !push)
				fillCnt <= fillCnt - 1'b1;

			if (popConfig)
				baudDiv <= headCmd.payload.asConfig;  // tick gen sees it next cycle
		end
	end

endmodule

// ==== verilog/uartTrans.sv ====
//////////////////////////////////////////////////
// 8N1 serializer
// idle/start/data/stop FSM, registered tx
//////////////////////////////////////////////////

`include "uart_params.svh"

module uartTrans import uartFramePkg::*;
(
	input  logic   clk,
	input  logic   reset,
	input  logic   sTick,     // 16x baud tick
	input  logic   txValid,
	input  txByteT txByte,
	output logic   txAccept,  // pulse, byte taken
	output logic   busy,
	output logic   tx          // serial line
);

	localparam int tickCntLen = $clog2(`sbTick);
	localparam int bitCntLen  = $clog2(`dataBits);

	txStateT               stateReg, stateNext;
	logic [tickCntLen-1:0] sReg, sNext;    // ticks within a bit
	logic [bitCntLen-1:0]  nReg, nNext;    // data bit index
	txByteT                bReg, bNext;    // shift register
	logic                  txReg, txNext;
	logic                  lastTick;       // final tick of the current bit

	assign lastTick = sTick && (sReg == tickCntLen'(`sbTick - 1));

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= stIdle;
			sReg     <= '0;
			nReg     <= '0;
			txReg    <= 1'b1;  // line idles high
		end
		else
		begin
			stateReg <= stateNext;
			sReg     <= sNext;
			nReg     <= nNext;
			txReg    <= txNext;
		end
	end

	always_ff @(posedge clk)
		bReg <= bNext;  // payload

	//////////////////////////////////////////////////
	// next state

	always_comb
	begin
		stateNext = stateReg;
		sNext     = sReg;
		nNext     = nReg;
		bNext     = bReg;
		txNext    = txReg;
		txAccept  = 1'b0;
		// tx follows the state one clock later, same for every bit
		case (stateReg)
			stIdle:
			begin
				txNext = 1'b1;
				if (txValid)
				begin
					txAccept  = 1'b1;    // pop at the intake
					bNext     = txByte;
					sNext     = '0;
					stateNext = stStart;
				end
			end
			stStart:
			begin
				txNext = 1'b0;  // start bit
				if (lastTick)
				begin
					sNext     = '0;
					nNext     = '0;
					stateNext = stData;
				end
				else if (sTick)
					sNext = sReg + 1'b1;
			end
			stData:
			begin
				txNext = bReg[0];  // lsb first
				if (lastTick)
				begin
					sNext = '0;
					bNext = bReg >> 1;
					if (nReg == bitCntLen'(`dataBits - 1))
						stateNext = stStop;
					else
						nNext = nReg + 1'b1;
				end
				else if (sTick)
					sNext = sReg + 1'b1;
			end
			stStop:
			begin
				txNext = 1'b1;
				if (lastTick)
				begin
					sNext     = '0;
					stateNext = stIdle;  // ready for the next byte next cycle
				end
				else if (sTick)
					sNext = sReg + 1'b1;
			end
			default: stateNext = stIdle;
		endcase
	end

	assign busy = (stateReg != stIdle);
	assign tx   = txReg;

endmodule

// ==== verilog/uartTxTop.sv ====
//////////////////////////////////////////////////
// uart transmit top level
// intake, baud tick generator, serializer
//////////////////////////////////////////////////

`include "uart_params.svh"

module uartTxTop import uartHostPkg::*, uartFramePkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  logic    cmdValid,
	input  hostCmdT cmd,
	output logic    creditReturn,
	output logic    tx
);

	logic                   txValid;   // intake to serializer
	txByteT                 txByte;
	logic                   txAccept;  // serializer back to intake
	logic                   busy;
	logic [`baudDivLen-1:0] baudDiv;   // intake to tick gen
	logic                   sTick;

	txIntake intake_i (.clk, .reset, .cmdValid, .cmd, .creditReturn,
		.txValid, .txByte, .txAccept, .busy, .baudDiv);

	baudTickGen tickGen_i (.clk, .reset, .baudDiv, .sTick);

	// tx comes straight off the serializer register
	uartTrans trans_i (.clk, .reset, .sTick, .txValid, .txByte,
		.txAccept, .busy, .tx);

endmodule

// ==== bench/serialMonitor.sv ====
//////////////////////////////////////////////////
// serial line monitor
// finds each start bit, samples mid-bit
// records byte and measured clocks per bit
//////////////////////////////////////////////////

module serialMonitor
(
	input  logic clk,
	input  logic reset,
	input  logic tx,
	input  int   bitClocks,    // rate the bench says is active
	output int   frameErrors
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [7:0] rxBytes [$];  // oldest first
	int         rxLens [$];   // 0 when a frame has too few edges

	logic       inFrame;
	logic       lastTx;
	logic [7:0] shiftByte;
	int         bitLen;       // latched at the falling edge
	int         cnt;          // clocks since the falling edge
	int         bitIdx;       // next bit to sample, 0 start ... 9 stop
	int         edgeBit;
	int         firstBit;
	int         firstCnt;
	int         lastBit;
	int         lastCnt;
	int         measured;

	// tx is registered, so mid-cycle is stable
	always @(negedge clk)
	begin
		if (reset)
		begin
			inFrame     = 1'b0;
			frameErrors = 0;
		end
		else if (!inFrame)
		begin
			if (!tx)
			begin
				inFrame  = 1'b1;  // start bit found
				bitLen   = bitClocks;
				cnt      = 0;
				bitIdx   = 0;
				firstBit = -1;
				lastBit  = -1;
			end
		end
		else
		begin
			cnt++;
			if (tx != lastTx)
			begin
				// start bit may run short, later boundaries sit on whole bits
				edgeBit = (cnt + bitLen / 2) / bitLen;
				if (firstBit < 0)
				begin
					firstBit = edgeBit;
					firstCnt = cnt;
				end
				lastBit = edgeBit;
				lastCnt = cnt;
			end
			if (cnt == bitIdx * bitLen + bitLen / 2)  // middle of the bit
			begin
				if (bitIdx == 0 && tx)
				begin
					$display("start bit glitch at %0t, frame dropped", $time);
					frameErrors++;
					inFrame = 1'b0;
				end
				else if (bitIdx == 9)
				begin
					if (!tx)
					begin
						$display("bad stop bit at %0t", $time);
						frameErrors++;
					end
					measured = 0;
					if (lastBit > firstBit)
						measured = (lastCnt - firstCnt) / (lastBit - firstBit);
					rxBytes.push_back(shiftByte);
					rxLens.push_back(measured);
					inFrame = 1'b0;
				end
				else if (bitIdx > 0)
					shiftByte = {tx, shiftByte[7:1]};  // lsb arrives first
				bitIdx++;
			end
		end
		lastTx = tx;
	end

endmodule

// ==== bench/uartTxBench.sv ====
//////////////////////////////////////////////////
// uart transmit testbench
// clock, reset, host credit tracking, LFSR bytes
// directed tests, timeout, closing summary
//////////////////////////////////////////////////

`include "uart_params.svh"

module uartTxBench import uartHostPkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	// 61 frames of 640 clocks times 4 for the slowest rate plus margin
	localparam int timeoutCycles = 61 * 640 * 4 + 2000;

	logic        clk = 1'b0;
	logic        reset;
	logic        cmdValid;
	hostCmdT     cmd;
	logic        creditReturn;
	logic        tx;
	int          monBitClocks;
	int          frameErrors;
	int          valueErrors = 0;
	int          otherErrors = 0;
	int          credits = `fifoDepth;  // host side count
	int          creditPulses = 0;
	int          cycleCount = 0;
	int          curDiv = `defaultBaudDiv;
	logic [15:0] lfsrState = 16'd60;
	logic [7:0]  expBytes [$];
	int          expLens [$];

	uartTxTop dut_i (.clk, .reset, .cmdValid, .cmd, .creditReturn, .tx);

	serialMonitor mon_i (.clk, .reset, .tx, .bitClocks(monBitClocks), .frameErrors);

	always #5 clk = ~clk;

	always @(negedge clk)
	begin
		if (!reset && creditReturn)
		begin
			credits++;       // one credit per pop
			creditPulses++;
		end
	end

	//////////////////////////////////////////////////
	// helpers

	task automatic printSummary();
		$display("errors: %0d (value %0d, other %0d, frame %0d)",
			valueErrors + otherErrors + frameErrors, valueErrors,
			otherErrors, frameErrors);
	endtask

	always @(posedge clk)
	begin
		cycleCount++;
		if (cycleCount >= timeoutCycles)
		begin
			$display("timeout after %0d cycles, %0d frames never arrived",
				cycleCount, expBytes.size());
			printSummary();
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	task automatic waitCycle();
		@(posedge clk);
		#1;  // drive point
	endtask

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] got);
		if (got !== expected)
		begin
			$display("** Error: %s expected 0x%0h got 0x%0h at %0t",
				name, expected, got, $time);
			valueErrors++;
		end
	endtask

	task automatic reportFailure(input string what);
		$display("%s at %0t", what, $time);
		otherErrors++;
	endtask

	// galois form with taps 16 14 13 11
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic randomByte(output logic [7:0] b);
		for (int i = 0; i < 8; i++)
		begin
			lfsrState = lfsrNext(lfsrState);  // one step per bit
			b = {b[6:0], lfsrState[0]};
		end
	endtask

	task automatic sendWord(input hostCmdT c);
		while (credits == 0)
			waitCycle();  // host stalls while out of credits
		cmdValid = 1'b1;
		cmd      = c;
		credits--;
		waitCycle();
		cmdValid = 1'b0;
	endtask

	task automatic sendByte(input logic [7:0] b);
		hostCmdT c;
		c.kind           = kindData;
		c.payload.asData = b;
		expBytes.push_back(b);
		expLens.push_back(`sbTick * (curDiv + 1));
		sendWord(c);
	endtask

	task automatic sendConfig(input logic [7:0] div);
		hostCmdT c;
		c.kind             = kindConfig;
		c.payload.asConfig = div;
		curDiv             = int'(div);  // applies to bytes sent after it
		sendWord(c);
	endtask

	task automatic collectFrames(input int n, input bit needLen);
		logic [7:0] gotByte;
		int         gotLen;
		for (int i = 0; i < n; i++)
		begin
			while (mon_i.rxBytes.size() == 0)
				waitCycle();
			gotByte = mon_i.rxBytes.pop_front();
			gotLen  = mon_i.rxLens.pop_front();
			if (expBytes.size() == 0)
				reportFailure("frame received with no byte outstanding");
			else
			begin
				checkValue("rx byte", 32'(expBytes[0]), 32'(gotByte));
				if (needLen || gotLen != 0)  // one in-frame edge gives no length
					checkValue("bit length", expLens[0], gotLen);
				void'(expBytes.pop_front());
				void'(expLens.pop_front());
			end
		end
	endtask

	//////////////////////////////////////////////////
	// tests

	task automatic testReset();
		reset        = 1'b1;
		cmdValid     = 1'b0;
		cmd          = '0;
		monBitClocks = `sbTick * (curDiv + 1);
		repeat (24)
		begin
			if (cycleCount == 4)
				reset = 1'b0;
			waitCycle();
			checkValue("tx", 32'd1, 32'(tx));
			checkValue("creditReturn", 32'd0, 32'(creditReturn));
		end
	endtask

	task automatic testSingleFrame();
		sendByte(8'hA5);
		collectFrames(1, 1'b1);
	endtask

	task automatic testBurst();
		int startPulses;
		startPulses = creditPulses;
		for (int i = 0; i < `fifoDepth; i++)
			sendByte(8'(i * 29 + 7));
		collectFrames(`fifoDepth, 1'b0);
		checkValue("creditReturn pulses", `fifoDepth, creditPulses - startPulses);
		checkValue("credits", `fifoDepth, credits);
	endtask

	task automatic testDivisorChange();
		int startPulses;
		startPulses = creditPulses;
		sendByte(8'h3C);
		sendByte(8'h96);
		sendConfig(8'd7);
		sendByte(8'h5A);
		sendByte(8'hC3);
		collectFrames(2, 1'b1);
		monBitClocks = `sbTick * (curDiv + 1);  // new rate for the frames after the config
		collectFrames(2, 1'b1);
		checkValue("creditReturn pulses", 32'd5, creditPulses - startPulses);
		checkValue("credits", `fifoDepth, credits);
	endtask

	task automatic testCreditStall();
		logic [7:0] b;
		for (int i = 0; i < 40; i++)
		begin
			randomByte(b);
			sendByte(b);
		end
		collectFrames(40, 1'b0);
		checkValue("credits", `fifoDepth, credits);
	endtask

	initial
	begin
		testReset();
		testSingleFrame();
		testBurst();
		testDivisorChange();
		testCreditStall();
		// a stray frame needs a whole frame time at the active rate to show up
		repeat (2 * 10 * `sbTick * (curDiv + 1))
			waitCycle();
		if (mon_i.rxBytes.size() != 0)
			reportFailure("frames received beyond those sent");
		printSummary();
		if (valueErrors + otherErrors + frameErrors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+verilog
verilog/uartFramePkg.sv
verilog/uartHostPkg.sv
verilog/baudTickGen.sv
verilog/txIntake.sv
verilog/uartTrans.sv
verilog/uartTxTop.sv
bench/serialMonitor.sv
bench/uartTxBench.sv

// ==== run.sh ====
#!/bin/sh
# build and run the uart transmit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
	-f tb.f --top-module uartTxBench \
	-Mdir obj_dir -o uartTxSim

./obj_dir/uartTxSim > sim.log 2>&1
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
	exit 1
fi
exit 0
